/* Makefile */
VERILATOR ?= verilator
FILELIST  := mips_decode.f
TB_TOP    := decode_tb
RTL_TOP   := decode_top
VFLAGS    := --timing --assert
BUILD_DIR := obj_dir
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: $(BUILD_DIR)/$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/alu_decoder.sv */
module alu_decoder import decode_pkg::*; #(
	parameter bit HAS_SPECIAL2 = 1'b1
) (
	input  logic [31:0] instr,
	output alu_ctrl_t   alu_ctrl
);

	opcode_e    opcode;
	regimm_e    rt;
	funct_e     funct;
	logic [5:0] fn;

	assign opcode = opcode_e'(instr[31:26]);
	assign rt     = regimm_e'(instr[20:16]);
	assign fn     = instr[5:0];
	assign funct  = funct_e'(fn);

	always_comb begin
		alu_ctrl.alu_op        = ALU_NOP;
		alu_ctrl.shamt_from_rs = 1'b0;
		alu_ctrl.md_op         = MD_NONE;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD:  alu_ctrl.alu_op = ALU_ADD;
					FN_ADDU: alu_ctrl.alu_op = ALU_ADDU;
					FN_SUB:  alu_ctrl.alu_op = ALU_SUB;
					FN_SUBU: alu_ctrl.alu_op = ALU_SUBU;
					FN_SLT:  alu_ctrl.alu_op = ALU_SLT;
					FN_SLTU: alu_ctrl.alu_op = ALU_SLTU;
					FN_AND:  alu_ctrl.alu_op = ALU_AND;
					FN_OR:   alu_ctrl.alu_op = ALU_OR;
					FN_XOR:  alu_ctrl.alu_op = ALU_XOR;
					FN_NOR:  alu_ctrl.alu_op = ALU_NOR;
					FN_SLL:  alu_ctrl.alu_op = ALU_SLL;
					FN_SRL:  alu_ctrl.alu_op = ALU_SRL;
					FN_SRA:  alu_ctrl.alu_op = ALU_SRA;
					FN_SLLV, FN_SRLV, FN_SRAV: begin
						alu_ctrl.shamt_from_rs = 1'b1;
						alu_ctrl.alu_op = (funct == FN_SLLV) ? ALU_SLL :
							(funct == FN_SRLV) ? ALU_SRL : ALU_SRA;
					end
					FN_MFHI, FN_MFLO, FN_MOVZ, FN_MOVN: alu_ctrl.alu_op = ALU_PASS_A;
					FN_JALR:  alu_ctrl.alu_op = ALU_ADDU; // pc + 8
					FN_MULT:  alu_ctrl.md_op  = MD_MULT;
					FN_MULTU: alu_ctrl.md_op  = MD_MULTU;
					FN_DIV:   alu_ctrl.md_op  = MD_DIV;
					FN_DIVU:  alu_ctrl.md_op  = MD_DIVU;
					FN_MTHI:  alu_ctrl.md_op  = MD_MTHI;
					FN_MTLO:  alu_ctrl.md_op  = MD_MTLO;
					default:  alu_ctrl.alu_op = ALU_NOP;
				endcase
			end
			OP_ADDI:  alu_ctrl.alu_op = ALU_ADD;
			OP_ADDIU: alu_ctrl.alu_op = ALU_ADDU;
			OP_SLTI:  alu_ctrl.alu_op = ALU_SLT;
			OP_SLTIU: alu_ctrl.alu_op = ALU_SLTU;
			OP_ANDI:  alu_ctrl.alu_op = ALU_AND;
			OP_ORI:   alu_ctrl.alu_op = ALU_OR;
			OP_XORI:  alu_ctrl.alu_op = ALU_XOR;
			OP_LUI:   alu_ctrl.alu_op = ALU_LUI;
			// address is base + offset
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL,
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC: begin
				alu_ctrl.alu_op = ALU_ADDU;
			end
			OP_JAL: alu_ctrl.alu_op = ALU_ADDU;
			OP_REGIMM: begin
				if (rt inside {RT_BGEZAL, RT_BLTZAL, RT_BGEZALL, RT_BLTZALL})
					alu_ctrl.alu_op = ALU_ADDU; // link address
			end
			OP_SPECIAL2: begin
				if (HAS_SPECIAL2) begin
					case (fn)
						F2_MUL:   alu_ctrl.md_op  = MD_MUL;
						F2_MADD:  alu_ctrl.md_op  = MD_MADD;
						F2_MADDU: alu_ctrl.md_op  = MD_MADDU;
						F2_MSUB:  alu_ctrl.md_op  = MD_MSUB;
						F2_MSUBU: alu_ctrl.md_op  = MD_MSUBU;
						F2_CLZ:   alu_ctrl.alu_op = ALU_CLZ;
						F2_CLO:   alu_ctrl.alu_op = ALU_CLO;
						default:  alu_ctrl.alu_op = ALU_NOP;
					endcase
				end
			end
			default: alu_ctrl.alu_op = ALU_NOP;
		endcase
	end

endmodule

/* hw/decode_ctrl_merge.sv */
module decode_ctrl_merge import decode_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         instr_valid,
	input  main_ctrl_t   main_ctrl,
	input  alu_ctrl_t    alu_ctrl,
	output logic         ctrl_valid,
	output decode_ctrl_t ctrl
);

	decode_ctrl_t ctrl_next;

	always_comb begin
		ctrl_next.main_ctrl = main_ctrl;
		ctrl_next.alu_ctrl  = alu_ctrl;
		ctrl_next.hilo_wen  = (alu_ctrl.md_op != MD_NONE);
		// excepting instr must not touch any state
		if (main_ctrl.exc != EXC_NONE) begin
			ctrl_next.main_ctrl.reg_write_en = 1'b0;
			ctrl_next.main_ctrl.mem_write_en = 1'b0;
			ctrl_next.main_ctrl.mem_read_en  = 1'b0;
			ctrl_next.main_ctrl.cp0_wen      = 1'b0;
			ctrl_next.main_ctrl.tlb_op       = TLB_NONE;
			ctrl_next.alu_ctrl.md_op         = MD_NONE;
			ctrl_next.hilo_wen               = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_valid <= 1'b0;
			ctrl       <= '0;
		end else begin
			ctrl_valid <= instr_valid;
			if (instr_valid)
				ctrl <= ctrl_next; // holds otherwise
		end
	end

	a_valid_after_rst: assert property (@(posedge clk) rst |=> !ctrl_valid);

	// suppression has to survive the register into the next stage
	a_exc_quiet: assert property (@(posedge clk) disable iff (rst)
		ctrl.main_ctrl.exc != EXC_NONE |->
			!(ctrl.main_ctrl.reg_write_en || ctrl.main_ctrl.mem_write_en ||
			ctrl.main_ctrl.mem_read_en || ctrl.main_ctrl.cp0_wen || ctrl.hilo_wen) &&
			ctrl.main_ctrl.tlb_op == TLB_NONE && ctrl.alu_ctrl.md_op == MD_NONE);

endmodule

/* hw/decode_pkg.sv */
package decode_pkg;

	// major opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL  = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ      = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI     = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI     = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_COP0     = 6'h10, OP_BEQL   = 6'h14, OP_BNEL  = 6'h15, OP_BLEZL = 6'h16,
		OP_BGTZL    = 6'h17, OP_SPECIAL2 = 6'h1c,
		OP_LB       = 6'h20, OP_LH     = 6'h21, OP_LWL   = 6'h22, OP_LW    = 6'h23,
		OP_LBU      = 6'h24, OP_LHU    = 6'h25, OP_LWR   = 6'h26,
		OP_SB       = 6'h28, OP_SH     = 6'h29, OP_SWL   = 6'h2a, OP_SW    = 6'h2b,
		OP_SWR      = 6'h2e, OP_CACHE  = 6'h2f, OP_LL    = 6'h30, OP_PREF  = 6'h33,
		OP_SC       = 6'h38
	} opcode_e;

	// funct under SPECIAL
	typedef enum logic [5:0] {
		FN_SLL     = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
		FN_SRLV    = 6'h06, FN_SRAV  = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
		FN_MOVZ    = 6'h0a, FN_MOVN  = 6'h0b, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
		FN_SYNC    = 6'h0f, FN_MFHI  = 6'h10, FN_MTHI    = 6'h11, FN_MFLO  = 6'h12,
		FN_MTLO    = 6'h13, FN_MULT  = 6'h18, FN_MULTU   = 6'h19, FN_DIV   = 6'h1a,
		FN_DIVU    = 6'h1b, FN_ADD   = 6'h20, FN_ADDU    = 6'h21, FN_SUB   = 6'h22,
		FN_SUBU    = 6'h23, FN_AND   = 6'h24, FN_OR      = 6'h25, FN_XOR   = 6'h26,
		FN_NOR     = 6'h27, FN_SLT   = 6'h2a, FN_SLTU    = 6'h2b, FN_TGE   = 6'h30,
		FN_TGEU    = 6'h31, FN_TLT   = 6'h32, FN_TLTU    = 6'h33, FN_TEQ   = 6'h34,
		FN_TNE     = 6'h36
	} funct_e;

	// rt field under REGIMM
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'h00, RT_BGEZ   = 5'h01, RT_BLTZL   = 5'h02, RT_BGEZL   = 5'h03,
		RT_TGEI   = 5'h08, RT_TGEIU  = 5'h09, RT_TLTI    = 5'h0a, RT_TLTIU   = 5'h0b,
		RT_TEQI   = 5'h0c, RT_TNEI   = 5'h0e, RT_BLTZAL  = 5'h10, RT_BGEZAL  = 5'h11,
		RT_BLTZALL = 5'h12, RT_BGEZALL = 5'h13
	} regimm_e;

	// rs field under COP0
	typedef enum logic [4:0] {
		RS_MFC0 = 5'h00,
		RS_MTC0 = 5'h04,
		RS_CO   = 5'h10
	} cop0_rs_e;

	// funct under SPECIAL2, overlaps the SPECIAL codes
	localparam logic [5:0] F2_MADD  = 6'h00;
	localparam logic [5:0] F2_MADDU = 6'h01;
	localparam logic [5:0] F2_MUL   = 6'h02;
	localparam logic [5:0] F2_MSUB  = 6'h04;
	localparam logic [5:0] F2_MSUBU = 6'h05;
	localparam logic [5:0] F2_CLZ   = 6'h20;
	localparam logic [5:0] F2_CLO   = 6'h21;

	// funct under COP0 with CO set
	localparam logic [5:0] CO_TLBR  = 6'h01;
	localparam logic [5:0] CO_TLBWI = 6'h02;
	localparam logic [5:0] CO_TLBWR = 6'h06;
	localparam logic [5:0] CO_TLBP  = 6'h08;
	localparam logic [5:0] CO_ERET  = 6'h18;
	localparam logic [5:0] CO_WAIT  = 6'h20;

	typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} reg_dst_e;

	typedef enum logic [3:0] {
		LS_NONE, LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_LWL, LS_LWR,
		LS_LL, LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR, LS_SC
	} ls_type_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOR, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA, ALU_CLZ, ALU_CLO,
		ALU_PASS_A, ALU_NOP
	} alu_op_e;

	typedef enum logic [3:0] {
		MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU, MD_MUL,
		MD_MADD, MD_MADDU, MD_MSUB, MD_MSUBU, MD_MTHI, MD_MTLO
	} md_op_e;

	typedef enum logic [1:0] {HL_NONE, HL_HI, HL_LO} hilo_sel_e;

	typedef enum logic [2:0] {TLB_NONE, TLB_P, TLB_R, TLB_WI, TLB_WR} tlb_op_e;

	typedef enum logic [2:0] {EXC_NONE, EXC_RI, EXC_SYSCALL, EXC_BREAK, EXC_ERET} exc_e;

	typedef struct packed {
		logic      reg_write_en;
		reg_dst_e  reg_dst;
		logic      alu_imm_sel;
		logic      sign_ext;
		logic      mem_read_en;
		logic      mem_write_en;
		logic      mem_to_reg;
		ls_type_e  ls_type;
		hilo_sel_e hilo_sel;
		logic      hilo_to_reg;
		logic      cp0_wen;
		logic      cp0_to_reg;
		tlb_op_e   tlb_op;
		logic      movz;
		logic      movn;
		exc_e      exc;
	} main_ctrl_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    shamt_from_rs; // variable shifts take rs[4:0]
		md_op_e  md_op;
	} alu_ctrl_t;

	typedef struct packed {
		main_ctrl_t main_ctrl;
		alu_ctrl_t  alu_ctrl;
		logic       hilo_wen;
	} decode_ctrl_t;

endpackage

/* hw/decode_top.sv */
module decode_top import decode_pkg::*; #(
	parameter bit HAS_SPECIAL2 = 1'b1
) (
	input  logic         clk,
	input  logic         rst,
	input  logic [31:0]  instr,
	input  logic         instr_valid,
	output logic         ctrl_valid,
	output decode_ctrl_t ctrl
);

	main_ctrl_t main_ctrl;
	alu_ctrl_t  alu_ctrl;

	// both decoders see the same word in the same cycle
	main_decoder #(
		.HAS_SPECIAL2(HAS_SPECIAL2)
	) i_main (
		.instr     (instr),
		.main_ctrl (main_ctrl)
	);

	alu_decoder #(
		.HAS_SPECIAL2(HAS_SPECIAL2)
	) i_alu (
		.instr    (instr),
		.alu_ctrl (alu_ctrl)
	);

	decode_ctrl_merge i_merge (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.main_ctrl   (main_ctrl),
		.alu_ctrl    (alu_ctrl),
		.ctrl_valid  (ctrl_valid),
		.ctrl        (ctrl)
	);

endmodule

/* hw/main_decoder.sv */
module main_decoder import decode_pkg::*; #(
	parameter bit HAS_SPECIAL2 = 1'b1
) (
	input  logic [31:0] instr,
	output main_ctrl_t  main_ctrl
);

	opcode_e    opcode;
	cop0_rs_e   rs;
	regimm_e    rt;
	funct_e     funct;
	logic [5:0] fn;

	assign opcode = opcode_e'(instr[31:26]);
	assign rs     = cop0_rs_e'(instr[25:21]);
	assign rt     = regimm_e'(instr[20:16]);
	assign fn     = instr[5:0];
	assign funct  = funct_e'(fn);

	function automatic ls_type_e ls_kind(input opcode_e op);
		case (op)
			OP_LB:   return LS_LB;
			OP_LBU:  return LS_LBU;
			OP_LH:   return LS_LH;
			OP_LHU:  return LS_LHU;
			OP_LW:   return LS_LW;
			OP_LWL:  return LS_LWL;
			OP_LWR:  return LS_LWR;
			OP_LL:   return LS_LL;
			OP_SB:   return LS_SB;
			OP_SH:   return LS_SH;
			OP_SW:   return LS_SW;
			OP_SWL:  return LS_SWL;
			OP_SWR:  return LS_SWR;
			OP_SC:   return LS_SC;
			default: return LS_NONE;
		endcase
	endfunction

	always_comb begin
		main_ctrl = '0;
		// only the logical immediates zero extend
		main_ctrl.sign_ext = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
		main_ctrl.ls_type  = ls_kind(opcode);
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
						main_ctrl.reg_write_en = 1'b1;
						main_ctrl.reg_dst      = DST_RD;
					end
					FN_MFHI, FN_MFLO: begin
						main_ctrl.reg_write_en = 1'b1;
						main_ctrl.reg_dst      = DST_RD;
						main_ctrl.hilo_to_reg  = 1'b1;
						main_ctrl.hilo_sel     = (funct == FN_MFHI) ? HL_HI : HL_LO;
					end
					FN_MOVZ, FN_MOVN: begin
						main_ctrl.reg_write_en = 1'b1; // datapath cancels on condition
						main_ctrl.reg_dst      = DST_RD;
						main_ctrl.movz         = (funct == FN_MOVZ);
						main_ctrl.movn         = (funct == FN_MOVN);
					end
					FN_JALR: begin
						main_ctrl.reg_write_en = 1'b1;
						main_ctrl.reg_dst      = DST_RA;
					end
					FN_JR, FN_SYNC,
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO,
					FN_TGE, FN_TGEU, FN_TLT, FN_TLTU, FN_TEQ, FN_TNE: begin
						main_ctrl.reg_write_en = 1'b0; // no regfile write
					end
					FN_SYSCALL: main_ctrl.exc = EXC_SYSCALL;
					FN_BREAK:   main_ctrl.exc = EXC_BREAK;
					default:    main_ctrl.exc = EXC_RI;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				main_ctrl.reg_write_en = 1'b1;
				main_ctrl.reg_dst      = DST_RT;
				main_ctrl.alu_imm_sel  = 1'b1;
			end
			OP_REGIMM: begin
				case (rt)
					RT_BGEZAL, RT_BLTZAL, RT_BGEZALL, RT_BLTZALL: begin
						main_ctrl.reg_write_en = 1'b1;
						main_ctrl.reg_dst      = DST_RA;
					end
					RT_BGEZ, RT_BLTZ, RT_BGEZL, RT_BLTZL: begin
						main_ctrl.reg_write_en = 1'b0;
					end
					RT_TGEI, RT_TGEIU, RT_TLTI, RT_TLTIU, RT_TEQI, RT_TNEI: begin
						main_ctrl.alu_imm_sel = 1'b1; // compare against imm
					end
					default: main_ctrl.exc = EXC_RI;
				endcase
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL: begin
				main_ctrl.reg_write_en = 1'b1;
				main_ctrl.reg_dst      = DST_RT;
				main_ctrl.alu_imm_sel  = 1'b1;
				main_ctrl.mem_read_en  = 1'b1;
				main_ctrl.mem_to_reg   = 1'b1;
			end
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR: begin
				main_ctrl.alu_imm_sel  = 1'b1;
				main_ctrl.mem_write_en = 1'b1;
			end
			OP_SC: begin
				// success flag goes back to rt
				main_ctrl.reg_write_en = 1'b1;
				main_ctrl.reg_dst      = DST_RT;
				main_ctrl.alu_imm_sel  = 1'b1;
				main_ctrl.mem_write_en = 1'b1;
			end
			OP_JAL: begin
				main_ctrl.reg_write_en = 1'b1;
				main_ctrl.reg_dst      = DST_RA;
			end
			OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
			OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL, OP_CACHE, OP_PREF: begin
				main_ctrl.reg_write_en = 1'b0;
			end
			OP_COP0: begin
				case (rs)
					RS_MFC0: begin
						main_ctrl.reg_write_en = 1'b1;
						main_ctrl.reg_dst      = DST_RT;
						main_ctrl.cp0_to_reg   = 1'b1;
					end
					RS_MTC0: main_ctrl.cp0_wen = 1'b1;
					RS_CO: begin
						case (fn)
							CO_ERET:  main_ctrl.exc    = EXC_ERET;
							CO_TLBP:  main_ctrl.tlb_op = TLB_P;
							CO_TLBR:  main_ctrl.tlb_op = TLB_R;
							CO_TLBWI: main_ctrl.tlb_op = TLB_WI;
							CO_TLBWR: main_ctrl.tlb_op = TLB_WR;
							CO_WAIT: begin
							end
							default:  main_ctrl.exc    = EXC_RI;
						endcase
					end
					default: main_ctrl.exc = EXC_RI;
				endcase
			end
			OP_SPECIAL2: begin
				if (HAS_SPECIAL2) begin
					case (fn)
						F2_MUL, F2_CLZ, F2_CLO: begin
							main_ctrl.reg_write_en = 1'b1;
							main_ctrl.reg_dst      = DST_RD;
						end
						F2_MADD, F2_MADDU, F2_MSUB, F2_MSUBU: begin
							main_ctrl.reg_write_en = 1'b0; // accumulates into hi/lo
						end
						default: main_ctrl.exc = EXC_RI;
					endcase
				end else begin
					main_ctrl.exc = EXC_RI;
				end
			end
			default: main_ctrl.exc = EXC_RI;
		endcase
	end

	// loads and stores come from separate branches above
	always_comb begin
		a_mem_rw_excl: assert (!(main_ctrl.mem_read_en && main_ctrl.mem_write_en))
			else $error("main_decoder: read and write both set for %h", instr);
	end

endmodule

/* mips_decode.f */
hw/decode_pkg.sv
hw/main_decoder.sv
hw/alu_decoder.sv
hw/decode_ctrl_merge.sv
hw/decode_top.sv
tb/decode_checker.sv
tb/decode_tb.sv

/* tb/decode_checker.sv */
module decode_checker import decode_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         ctrl_valid,
	input  decode_ctrl_t ctrl,
	input  logic         exp_push,
	input  decode_ctrl_t exp_ctrl,
	output int           errors,
	output int           pending
);

	// decode_ctrl_t fields from the msb down
	string field_name [20] = '{"reg_write_en", "reg_dst", "alu_imm_sel", "sign_ext",
		"mem_read_en", "mem_write_en", "mem_to_reg", "ls_type", "hilo_sel", "hilo_to_reg",
		"cp0_wen", "cp0_to_reg", "tlb_op", "movz", "movn", "exc", "alu_op",
		"shamt_from_rs", "md_op", "hilo_wen"};
	int field_width [20] = '{1, 2, 1, 1, 1, 1, 1, 4, 2, 1, 1, 1, 3, 1, 1, 3, 5, 1, 4, 1};

	decode_ctrl_t exp_q [$];
	int           due_q [$]; // cycle in which ctrl_valid must show up
	decode_ctrl_t last_ctrl;
	int           cyc;

	task automatic compare_bundle(input decode_ctrl_t exp, input decode_ctrl_t act);
		logic [35:0] e;
		logic [35:0] a;
		logic [35:0] mask;
		logic [35:0] fe;
		logic [35:0] fa;
		int          pos;
		int          diffs;
		string       name;
		e = exp;
		a = act;
		pos = 36;
		diffs = 0;
		for (int i = 0; i < 20; i++) begin
			pos -= field_width[i];
			mask = (36'd1 << field_width[i]) - 36'd1;
			if ((((e ^ a) >> pos) & mask) !== 36'd0) begin
				diffs++;
				name = field_name[i];
				fe = (e >> pos) & mask;
				fa = (a >> pos) & mask;
			end
		end
		if (diffs == 1)
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, fe, fa);
		else if (diffs > 1)
			$display("** Error at %0t: ctrl expected %h, got %h", $time, e, a);
		if (diffs != 0)
			errors++;
	endtask

	// outputs are sampled half a cycle after the edge
	always @(negedge clk) begin
		if (rst) begin
			exp_q.delete();
			due_q.delete();
			last_ctrl = '0;
			cyc = 0;
			errors = 0;
		end else begin
			cyc++;
			if (ctrl_valid) begin
				if (exp_q.size() == 0) begin
					$display("ctrl_valid at %0t with no instruction outstanding", $time);
					errors++;
				end else begin
					if (due_q[0] != cyc) begin
						$display("ctrl_valid at %0t is not one cycle after its strobe", $time);
						errors++;
					end
					compare_bundle(exp_q.pop_front(), ctrl);
					void'(due_q.pop_front());
				end
				last_ctrl = ctrl;
			end else begin
				if (ctrl !== last_ctrl) begin
					$display("** Error at %0t: ctrl expected %h, got %h", $time, last_ctrl, ctrl);
					errors++;
				end
				if (due_q.size() != 0 && due_q[0] == cyc) begin
					$display("no ctrl_valid at %0t one cycle after a strobe", $time);
					errors++;
					void'(exp_q.pop_front());
					void'(due_q.pop_front());
				end
			end
			if (exp_push) begin
				exp_q.push_back(exp_ctrl);
				due_q.push_back(cyc + 1);
			end
		end
		pending = exp_q.size();
	end

endmodule

/* tb/decode_tb.sv */
module decode_tb import decode_pkg::*; ();

	logic         clk;
	logic         rst;
	logic [31:0]  instr;
	logic         instr_valid;
	logic         ctrl_valid;
	decode_ctrl_t ctrl;
	logic         exp_push;
	decode_ctrl_t exp_ctrl;
	int           errors;
	int           pending;
	int           fd;
	int           n_tests;
	int           gap;
	int           waited;
	logic [31:0]  word;
	logic [35:0]  expect_bits;
	string        line;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	decode_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ctrl_valid  (ctrl_valid),
		.ctrl        (ctrl)
	);

	decode_checker i_check (
		.clk        (clk),
		.rst        (rst),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl),
		.exp_push   (exp_push),
		.exp_ctrl   (exp_ctrl),
		.errors     (errors),
		.pending    (pending)
	);

	task automatic send_instr(input logic [31:0] w, input logic [35:0] e);
		@(posedge clk);
		#1;
		instr       = w;
		instr_valid = 1'b1;
		exp_push    = 1'b1;
		exp_ctrl    = decode_ctrl_t'(e);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		instr       = $urandom; // junk word, must not reach ctrl
		instr_valid = 1'b0;
		exp_push    = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hc2d4));
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		exp_push    = 1'b0;
		exp_ctrl    = '0;
		n_tests     = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (2) idle_cycle(); // ctrl stays zero before the first strobe
		fd = $fopen("tb/decode_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/decode_tests.txt");
			$display("Checks failed");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.substr(0, 1) != "//") begin
					if ($sscanf(line, "%h %h", word, expect_bits) == 2) begin
						send_instr(word, expect_bits);
						n_tests++;
						// every fourth one goes back to back
						gap = (n_tests % 4 == 0) ? 0 : $urandom_range(3, 0);
						repeat (gap) idle_cycle();
					end
				end
			end
			$fclose(fd);
			idle_cycle();
			waited = 0;
			while (pending != 0 && waited < 20) begin
				@(posedge clk);
				waited++;
			end
			repeat (2) idle_cycle();
			if (pending != 0)
				$display("%0d instructions got no ctrl_valid within 20 cycles", pending);
			if (n_tests == 0)
				$display("no instructions were read from tb/decode_tests.txt");
			$display("tests: %0d, errors: %0d, pending: %0d", n_tests, errors, pending);
			if (errors == 0 && pending == 0 && n_tests > 0)
				$display("All checks passed");
			else
				$display("Checks failed");
		end
		$finish;
	end

endmodule

/* tb/decode_tests.txt */
// instruction word (hex), expected decode_ctrl_t (36 bits, hex)
// the text after the two columns names the instruction
00221820 880000000 // add
00221823 8800000c0 // subu
00221804 8800002e0 // sllv
00021903 880000340 // sra
2022fffc b80000000 // addi
302200ff b00000180 // andi
3c021234 b00000280 // lui
80220010 bd1000040 // lb
94220010 bd4000040 // lhu
c0220010 bd8000040 // ll
a0220010 1a9000040 // sb
b8220010 1ad000040 // swr
e0220010 bae000040 // sc
0c000040 c80000040 // jal
0020f809 c80000040 // jalr
04310004 c80000040 // bgezal
10220004 080000440 // beq
08000040 080000440 // j
00220018 080000443 // mult
00200011 080000455 // mthi
00001810 880600400 // mfhi
00001812 880a00400 // mflo
70220000 08000044d // madd
70231820 880000380 // clz
70221802 88000044b // mul
40026000 a80080440 // mfc0
40826000 080100440 // mtc0
42000002 080030440 // tlbwi
0000000c 080001440 // syscall
0000000d 080001c40 // break
42000018 080002440 // eret
fc000000 080000c40 // reserved opcode
0022180a 880008400 // movz
